// ==== source/movegen_pkg.sv ====
package movegen_pkg;

  // board geometry, a square index is rank*8 + file so a1 is 0 and h8 is 63
  localparam int NUM_SQUARES = 64;
  localparam int SQ_W = 6;

  // default depth of each colour's piece stack and of the move queue
  localparam int STACK_DEPTH_DEF = 16;

  // piece codes as they arrive on the load bus
  typedef enum logic [2:0] {
    PC_EMPTY  = 3'd0,
    PC_KING   = 3'd1,
    PC_QUEEN  = 3'd2,
    PC_ROOK   = 3'd3,
    PC_BISHOP = 3'd4,
    PC_KNIGHT = 3'd5,
    PC_PAWN   = 3'd6
  } piece_e;

  // one square of the serial load, colour bit is 1 for white
  typedef struct packed {
    logic   white;
    piece_e piece;
  } pos_code_t;

  // one slot of a piece stack or of the move queue
  typedef struct packed {
    logic                full;
    piece_e              piece;
    logic [SQ_W-1:0]     square;
  } piece_entry_t;

  // move word, 3 bits per field from the piece down to the destination rank
  typedef struct packed {
    piece_e     piece;
    logic [2:0] from_file;
    logic [2:0] from_rank;
    logic [2:0] to_file;
    logic [2:0] to_rank;
  } uci_move_t;

endpackage

// ==== source/cand_if.sv ====
interface cand_if;

  // a destination was granted for the head piece this cycle
  logic                  valid;
  logic                  piece_done;
  logic                  last_piece;
  movegen_pkg::uci_move_t move;

  // the scan drives candidates and the emitter frames them
  modport scan (
    output valid,
    output move,
    output piece_done,
    output last_piece
  );

  modport emit (
    input valid,
    input move,
    input piece_done,
    input last_piece
  );

endinterface

// ==== source/piece_stack.sv ====
module piece_stack #(
  parameter int DEPTH = movegen_pkg::STACK_DEPTH_DEF
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_clear,
  input  logic                      i_push,
  input  movegen_pkg::piece_entry_t i_entry,
  output movegen_pkg::piece_entry_t o_entries [DEPTH]
);

  movegen_pkg::piece_entry_t slots [DEPTH];

  // a push moves every slot down by one and slot 0 takes the new piece
  // when the a1 code pushes in its own clear cycle, only that piece survives
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        slots[k] <= '0;
      end
    end else if (i_clear || i_push) begin
      for (int k = DEPTH - 1; k > 0; k--) begin
        slots[k] <= i_clear ? '0 : slots[k-1];
      end
      slots[0] <= i_push ? i_entry : '0;
    end
  end

  assign o_entries = slots;

  // the position may not hold more pieces of one colour than the stack depth
  a_no_overflow : assert property (
    @(posedge clk) disable iff (i_rst)
    (i_push && !i_clear) |-> !slots[DEPTH-1].full
  );

endmodule

// ==== source/move_queue.sv ====
module move_queue #(
  parameter int DEPTH = movegen_pkg::STACK_DEPTH_DEF
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_load,
  input  movegen_pkg::piece_entry_t i_load_entries [DEPTH],
  input  logic                      i_pop,
  output movegen_pkg::piece_entry_t o_head,
  output logic                      o_last
);

  movegen_pkg::piece_entry_t q [DEPTH];

  // parallel load of the side to play, then one pop per finished piece
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        q[k] <= '0;
      end
    end else if (i_load) begin
      q <= i_load_entries;
    end else if (i_pop) begin
      for (int k = 0; k < DEPTH - 1; k++) begin
        q[k] <= q[k+1];
      end
      q[DEPTH-1] <= '0;
    end
  end

  assign o_head = q[0];

  // the stack packs full entries from slot 0, so an empty second slot
  // means the head is the final piece of the list
  assign o_last = !q[1].full;

  // start is only legal once the previous list has ended, so the scan
  // can never be popping while a new list is loaded
  a_load_pop : assert property (
    @(posedge clk) disable iff (i_rst)
    !(i_load && i_pop)
  );

endmodule

// ==== source/board_square.sv ====
module board_square (
  input  logic                   clk,
  input  logic                   i_rst,

  // serial load chain
  input  logic                   i_pos_valid,
  input  movegen_pkg::pos_code_t i_pos_data,
  output movegen_pkg::pos_code_t o_pos_data,

  // control
  input  logic                   i_emit,
  input  logic                   i_wtp,
  output logic                   o_target,

  // rays, bit d is the direction of travel, clockwise from north
  // 0 n, 1 ne, 2 e, 3 se, 4 s, 5 sw, 6 w, 7 nw
  output logic [7:0]             o_slide,
  input  logic [7:0]             i_slide,
  output logic [7:0]             o_king,
  input  logic [7:0]             i_king,
  output logic [7:0]             o_knight,
  input  logic [7:0]             i_knight
);

  movegen_pkg::pos_code_t code;
  logic                   is_empty;
  logic                   is_own;
  logic                   emit_orth;
  logic                   emit_diag;
  logic                   emit_king;
  logic                   emit_knight;

  // each valid cycle the cell takes the code behind it and hands its
  // previous code on, so the first code loaded ends up in a1
  always_ff @(posedge clk) begin
    if (i_rst) begin
      code <= '0;
    end else if (i_pos_valid) begin
      code <= i_pos_data;
    end
  end

  assign o_pos_data = code;

  assign is_empty = (code.piece == movegen_pkg::PC_EMPTY);
  assign is_own   = !is_empty && (code.white == i_wtp);

  // queens use both ray sets, rooks the straight and bishops the diagonal
  // ones; a pawn only occupies the square
  assign emit_orth = i_emit && (code.piece == movegen_pkg::PC_QUEEN ||
                                code.piece == movegen_pkg::PC_ROOK);
  assign emit_diag = i_emit && (code.piece == movegen_pkg::PC_QUEEN ||
                                code.piece == movegen_pkg::PC_BISHOP);
  assign emit_king   = i_emit && (code.piece == movegen_pkg::PC_KING);
  assign emit_knight = i_emit && (code.piece == movegen_pkg::PC_KNIGHT);

  // even directions are straight and odd ones diagonal
  // an arriving slide ray only carries on through an empty cell
  assign o_slide = {emit_diag, emit_orth, emit_diag, emit_orth,
                    emit_diag, emit_orth, emit_diag, emit_orth} |
                   (i_slide & {8{is_empty}});

  // king and knight steps end here, they never ripple onward
  assign o_king   = {8{emit_king}};
  assign o_knight = {8{emit_knight}};

  // anything reaching this square is a destination unless the mover owns it
  assign o_target = !is_own && (|i_slide || |i_king || |i_knight);

endmodule

// ==== source/board_grid.sv ====
module board_grid (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic                                i_pos_valid,
  input  movegen_pkg::pos_code_t              i_pos_data,
  input  logic                                i_wtp,
  input  logic [movegen_pkg::SQ_W-1:0]        i_from,
  output logic [movegen_pkg::NUM_SQUARES-1:0] o_targets
);

  // step of each ray direction as rank and file offsets, clockwise from north
  localparam int DIR_R [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int DIR_F [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
  // the eight knight jumps in the same fashion
  localparam int JMP_R [8] = '{2, 2, -2, -2, 1, 1, -1, -1};
  localparam int JMP_F [8] = '{1, -1, 1, -1, 2, -2, 2, -2};

  logic [movegen_pkg::NUM_SQUARES-1:0] emit;
  movegen_pkg::pos_code_t              chain      [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          slide_out  [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          slide_in   [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          king_out   [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          king_in    [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          knight_out [movegen_pkg::NUM_SQUARES];
  logic [7:0]                          knight_in  [movegen_pkg::NUM_SQUARES];

  // only the head piece's square drives its rays
  assign emit = {{(movegen_pkg::NUM_SQUARES-1){1'b0}}, 1'b1} << i_from;

  for (genvar s = 0; s < movegen_pkg::NUM_SQUARES; s++) begin : g_sq
    localparam int R = s / 8;
    localparam int F = s % 8;

    for (genvar d = 0; d < 8; d++) begin : g_dir
      // the cell one step back along direction d feeds this cell's input d
      localparam int SR = R - DIR_R[d];
      localparam int SF = F - DIR_F[d];
      localparam int NR = R - JMP_R[d];
      localparam int NF = F - JMP_F[d];

      if (SR >= 0 && SR < 8 && SF >= 0 && SF < 8) begin : g_step
        assign slide_in[s][d] = slide_out[SR*8+SF][d];
        assign king_in[s][d]  = king_out[SR*8+SF][d];
      end else begin : g_step_edge
        assign slide_in[s][d] = 1'b0;
        assign king_in[s][d]  = 1'b0;
      end

      if (NR >= 0 && NR < 8 && NF >= 0 && NF < 8) begin : g_jump
        assign knight_in[s][d] = knight_out[NR*8+NF][d];
      end else begin : g_jump_edge
        assign knight_in[s][d] = 1'b0;
      end
    end

    // the load enters at h8 and walks down the chain towards a1
    board_square u_square (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_pos_valid (i_pos_valid),
      .i_pos_data  ((s == movegen_pkg::NUM_SQUARES - 1) ? i_pos_data : chain[(s+1) % 64]),
      .o_pos_data  (chain[s]),
      .i_emit      (emit[s]),
      .i_wtp       (i_wtp),
      .o_target    (o_targets[s]),
      .o_slide     (slide_out[s]),
      .i_slide     (slide_in[s]),
      .o_king      (king_out[s]),
      .i_king      (king_in[s]),
      .o_knight    (knight_out[s]),
      .i_knight    (knight_in[s])
    );
  end

endmodule

// ==== source/target_scan.sv ====
module target_scan (
  input  logic                                clk,
  input  logic                                i_rst,
  input  logic                                i_start,
  input  logic [movegen_pkg::NUM_SQUARES-1:0] i_targets,
  input  movegen_pkg::piece_entry_t           i_head,
  input  logic                                i_last,
  cand_if.scan                                cand,
  output logic                                o_pop
);

  localparam int W = movegen_pkg::NUM_SQUARES + 1;

  logic                        active;
  logic [W-1:0]                base;
  logic [W-1:0]                req;
  logic [W-1:0]                grant;
  logic                        done;
  logic [movegen_pkg::SQ_W-1:0] to_sq;

  // the top request bit never drops, so once the base passes every real
  // target the arbiter falls through to the end-of-piece bit
  // an empty head masks the board and finishes at once
  assign req   = {1'b1, i_targets & {movegen_pkg::NUM_SQUARES{i_head.full}}};
  assign grant = req & ~(req - base);

  assign done = active && grant[W-1];

  // list runs from the start pulse until the last piece has finished
  always_ff @(posedge clk) begin
    if (i_rst) begin
      active <= 1'b0;
      base   <= W'(1);
    end else begin
      if (i_start) begin
        active <= 1'b1;
      end else if (done && i_last) begin
        active <= 1'b0;
      end
      if (i_start || done) begin
        base <= W'(1);
      end else if (active) begin
        base <= grant << 1;
      end
    end
  end

  // one-hot to index of the granted destination
  always_comb begin
    to_sq = '0;
    for (int k = 0; k < movegen_pkg::NUM_SQUARES; k++) begin
      if (grant[k]) begin
        to_sq |= movegen_pkg::SQ_W'(k);
      end
    end
  end

  assign cand.valid      = active && !grant[W-1];
  assign cand.piece_done = done;
  assign cand.last_piece = i_last;
  assign cand.move       = '{piece:     i_head.piece,
                             from_file: i_head.square[2:0],
                             from_rank: i_head.square[5:3],
                             to_file:   to_sq[2:0],
                             to_rank:   to_sq[5:3]};

  assign o_pop = done;

  // the queue keeps its full entries packed from the head, so an empty
  // head may only show up as the final entry of a running list
  a_empty_head_last : assert property (
    @(posedge clk) disable iff (i_rst)
    (active && !i_head.full) |-> i_last
  );

endmodule

// ==== source/uci_emitter.sv ====
module uci_emitter (
  input  logic                   clk,
  input  logic                   i_rst,
  cand_if.emit                   cand,
  output logic                   o_uci_valid,
  output movegen_pkg::uci_move_t o_uci_data,
  output logic                   o_uci_sop,
  output logic                   o_uci_eop
);

  movegen_pkg::uci_move_t buf_move;
  logic                   buf_valid;
  logic                   buf_sop;
  logic                   seen_first;
  logic                   last_done;
  logic                   release_buf;

  // whether a move is the last one is only known once the next one turns
  // up or the final piece reports that it has nothing left
  assign last_done   = cand.piece_done && cand.last_piece;
  assign release_buf = cand.valid || last_done;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      buf_valid   <= 1'b0;
      buf_sop     <= 1'b0;
      seen_first  <= 1'b0;
      o_uci_valid <= 1'b0;
      o_uci_sop   <= 1'b0;
      o_uci_eop   <= 1'b0;
    end else begin
      if (cand.valid) begin
        buf_sop <= !seen_first;
      end
      // the end of a list re-arms the sop marking for the next one
      if (release_buf) begin
        buf_valid  <= cand.valid;
        seen_first <= (seen_first || cand.valid) && !last_done;
      end
      o_uci_valid <= buf_valid && release_buf;
      o_uci_sop   <= buf_valid && buf_sop && release_buf;
      // with no buffered move this is the lone eop of an empty list
      o_uci_eop   <= last_done;
    end
  end

  // move payload
  always_ff @(posedge clk) begin
    if (cand.valid) begin
      buf_move <= cand.move;
    end
    if (release_buf) begin
      o_uci_data <= buf_move;
    end
  end

endmodule

// ==== source/movegen_top.sv ====
module movegen_top #(
  parameter int STACK_DEPTH = movegen_pkg::STACK_DEPTH_DEF
) (
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic                   i_pos_valid,
  input  logic                   i_pos_sop,
  input  movegen_pkg::pos_code_t i_pos_data,
  input  logic                   i_wtp,
  input  logic                   i_start,
  output logic                   o_uci_valid,
  output movegen_pkg::uci_move_t o_uci_data,
  output logic                   o_uci_sop,
  output logic                   o_uci_eop
);

  logic [movegen_pkg::SQ_W-1:0]        sq_count;
  logic [movegen_pkg::SQ_W-1:0]        load_sq;
  logic                                pos_clear;
  logic                                is_piece;
  logic                                push_white;
  logic                                push_black;
  movegen_pkg::piece_entry_t           load_entry;
  movegen_pkg::piece_entry_t           white_entries [STACK_DEPTH];
  movegen_pkg::piece_entry_t           black_entries [STACK_DEPTH];
  movegen_pkg::piece_entry_t           play_entries  [STACK_DEPTH];
  movegen_pkg::piece_entry_t           head;
  logic                                last;
  logic                                pop;
  logic [movegen_pkg::NUM_SQUARES-1:0] targets;

  cand_if u_cand ();

  // square of the code on the bus, sop always marks a1
  always_ff @(posedge clk) begin
    if (i_rst) begin
      sq_count <= '0;
    end else if (i_pos_valid) begin
      sq_count <= load_sq + 1'b1;
    end
  end

  assign load_sq    = i_pos_sop ? '0 : sq_count;
  assign pos_clear  = i_pos_valid && i_pos_sop;
  assign is_piece   = (i_pos_data.piece != movegen_pkg::PC_EMPTY);
  assign push_white = i_pos_valid && is_piece && i_pos_data.white;
  assign push_black = i_pos_valid && is_piece && !i_pos_data.white;
  assign load_entry = '{full: 1'b1, piece: i_pos_data.piece, square: load_sq};

  // both stacks see every code but only the matching colour pushes
  piece_stack #(.DEPTH(STACK_DEPTH)) u_stack_white (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_clear   (pos_clear),
    .i_push    (push_white),
    .i_entry   (load_entry),
    .o_entries (white_entries)
  );

  piece_stack #(.DEPTH(STACK_DEPTH)) u_stack_black (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_clear   (pos_clear),
    .i_push    (push_black),
    .i_entry   (load_entry),
    .o_entries (black_entries)
  );

  always_comb begin
    for (int k = 0; k < STACK_DEPTH; k++) begin
      play_entries[k] = i_wtp ? white_entries[k] : black_entries[k];
    end
  end

  move_queue #(.DEPTH(STACK_DEPTH)) u_queue (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_load         (i_start),
    .i_load_entries (play_entries),
    .i_pop          (pop),
    .o_head         (head),
    .o_last         (last)
  );

  board_grid u_board (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_pos_valid (i_pos_valid),
    .i_pos_data  (i_pos_data),
    .i_wtp       (i_wtp),
    .i_from      (head.square),
    .o_targets   (targets)
  );

  target_scan u_scan (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_start   (i_start),
    .i_targets (targets),
    .i_head    (head),
    .i_last    (last),
    .cand      (u_cand),
    .o_pop     (pop)
  );

  uci_emitter u_emitter (
    .clk         (clk),
    .i_rst       (i_rst),
    .cand        (u_cand),
    .o_uci_valid (o_uci_valid),
    .o_uci_data  (o_uci_data),
    .o_uci_sop   (o_uci_sop),
    .o_uci_eop   (o_uci_eop)
  );

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #50 o_clk = ~o_clk;
    end
  end

  // reset drops on a falling edge, half a cycle away from the DUT's sampling edge
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

// ==== sim/tb_movegen.sv ====
module tb_movegen;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int STACK_DEPTH = movegen_pkg::STACK_DEPTH_DEF;
  // a run loads 64 codes, scans at most 65 cycles per piece and then drains
  localparam int RUN_CYCLES  = 64 + STACK_DEPTH * 65 + 20;
  localparam int CYCLE_LIMIT = 40 * RUN_CYCLES;
  localparam int RANDOM_RUNS = 34;

  // king steps clockwise from north, straight ones sit on even indices
  localparam int STEP_R [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
  localparam int STEP_F [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
  localparam int JUMP_R [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
  localparam int JUMP_F [8] = '{2, 1, -1, -2, -2, -1, 1, 2};

  logic                   clk;
  logic                   i_rst;
  logic                   i_pos_valid;
  logic                   i_pos_sop;
  movegen_pkg::pos_code_t i_pos_data;
  logic                   i_wtp;
  logic                   i_start;
  logic                   o_uci_valid;
  movegen_pkg::uci_move_t o_uci_data;
  logic                   o_uci_sop;
  logic                   o_uci_eop;

  logic [15:0] lfsr_state;
  logic [3:0]  board_codes [64];
  logic [14:0] exp_moves [$];
  logic [14:0] got_moves [$];
  bit          lone_eop;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;

  tb_clock #(.RESET_CYCLES(10)) u_clock (
    .o_clk (clk),
    .o_rst (i_rst)
  );

  movegen_top #(.STACK_DEPTH(STACK_DEPTH)) u_movegen_top (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_pos_valid (i_pos_valid),
    .i_pos_sop   (i_pos_sop),
    .i_pos_data  (i_pos_data),
    .i_wtp       (i_wtp),
    .i_start     (i_start),
    .o_uci_valid (o_uci_valid),
    .o_uci_data  (o_uci_data),
    .o_uci_sop   (o_uci_sop),
    .o_uci_eop   (o_uci_eop)
  );

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // one LFSR step for every bit taken, least significant bit first
  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = v | (int'(lfsr_state[0]) << k);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [2:0] piece_from_bits(input int v);
    case (v)
      0:       return movegen_pkg::PC_KING;
      1:       return movegen_pkg::PC_QUEEN;
      2, 7:    return movegen_pkg::PC_ROOK;
      3:       return movegen_pkg::PC_BISHOP;
      5:       return movegen_pkg::PC_PAWN;
      default: return movegen_pkg::PC_KNIGHT;
    endcase
  endfunction

  function automatic bit on_board(input int r, input int f);
    return r >= 0 && r < 8 && f >= 0 && f < 8;
  endfunction

  function automatic bit mover_owns(input int sq, input logic wtp);
    return board_codes[sq][2:0] != 3'd0 && board_codes[sq][3] == wtp;
  endfunction

  // every square the piece on sq may move to, empty or opponent held
  function automatic logic [63:0] reach_mask(input int sq, input logic wtp);
    logic [2:0]  p;
    logic [63:0] m;
    bit          orth;
    bit          diag;
    bit          blocked;
    int          r;
    int          f;
    p    = board_codes[sq][2:0];
    m    = '0;
    orth = (p == movegen_pkg::PC_QUEEN) || (p == movegen_pkg::PC_ROOK);
    diag = (p == movegen_pkg::PC_QUEEN) || (p == movegen_pkg::PC_BISHOP);
    for (int d = 0; d < 8; d++) begin
      // a ray stops on the first occupied square and takes it if it is the opponent's
      if ((d % 2 == 0) ? orth : diag) begin
        r = sq / 8 + STEP_R[d];
        f = sq % 8 + STEP_F[d];
        blocked = 1'b0;
        while (!blocked && on_board(r, f)) begin
          if (!mover_owns(r * 8 + f, wtp)) begin
            m[r*8+f] = 1'b1;
          end
          blocked = (board_codes[r*8+f][2:0] != 3'd0);
          r = r + STEP_R[d];
          f = f + STEP_F[d];
        end
      end
      if (p == movegen_pkg::PC_KING) begin
        r = sq / 8 + STEP_R[d];
        f = sq % 8 + STEP_F[d];
        if (on_board(r, f) && !mover_owns(r * 8 + f, wtp)) begin
          m[r*8+f] = 1'b1;
        end
      end
      if (p == movegen_pkg::PC_KNIGHT) begin
        r = sq / 8 + JUMP_R[d];
        f = sq % 8 + JUMP_F[d];
        if (on_board(r, f) && !mover_owns(r * 8 + f, wtp)) begin
          m[r*8+f] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  // piece, from file, from rank, to file, to rank
  function automatic logic [14:0] pack_move(input logic [2:0] p, input int src, input int dst);
    return {p, 3'(src % 8), 3'(src / 8), 3'(dst % 8), 3'(dst / 8)};
  endfunction

  // pieces leave the queue from the highest square down, each lists targets upward
  function automatic void build_expected(input logic wtp);
    logic [63:0] m;
    exp_moves.delete();
    for (int sq = 63; sq >= 0; sq--) begin
      if (mover_owns(sq, wtp)) begin
        m = reach_mask(sq, wtp);
        for (int t = 0; t < 64; t++) begin
          if (m[t]) begin
            exp_moves.push_back(pack_move(board_codes[sq][2:0], sq, t));
          end
        end
      end
    end
  endfunction

  function automatic bit contains_move(input logic [14:0] mv);
    foreach (got_moves[k]) begin
      if (got_moves[k] == mv) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic int count_from(input int sq);
    int n;
    n = 0;
    foreach (got_moves[k]) begin
      if (int'(got_moves[k][8:6]) * 8 + int'(got_moves[k][11:9]) == sq) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests++;
    $display("test %s done with %0d errors", name, errors - mark);
  endtask

  task automatic clear_board();
    foreach (board_codes[sq]) begin
      board_codes[sq] = 4'h0;
    end
  endtask

  // roughly three squares in eight are taken, each colour capped at the stack depth
  task automatic make_random_board();
    int occ;
    int kind;
    int colour;
    int count_w;
    int count_b;
    count_w = 0;
    count_b = 0;
    clear_board();
    for (int sq = 0; sq < 64; sq++) begin
      take_bits(3, occ);
      if (occ < 3) begin
        take_bits(3, kind);
        take_bits(1, colour);
        if (colour == 1 && count_w < STACK_DEPTH) begin
          board_codes[sq] = {1'b1, piece_from_bits(kind)};
          count_w++;
        end else if (colour == 0 && count_b < STACK_DEPTH) begin
          board_codes[sq] = {1'b0, piece_from_bits(kind)};
          count_b++;
        end
      end
    end
  endtask

  // each move has to start on a square that holds that piece of the side to play
  task automatic check_colours(input logic wtp);
    int src;
    foreach (got_moves[k]) begin
      src = int'(got_moves[k][8:6]) * 8 + int'(got_moves[k][11:9]);
      expect_true(mover_owns(src, wtp) && board_codes[src][2:0] == got_moves[k][14:12],
                  "a move starts on a square the side to play does not hold");
    end
  endtask

  // load a1 to h8, pulse start, then follow the list until eop
  task automatic run_position(input logic wtp);
    int idx;
    bit ended;
    build_expected(wtp);
    got_moves.delete();
    lone_eop = 1'b0;
    i_wtp = wtp;
    for (int sq = 0; sq < 64; sq++) begin
      @(negedge clk);
      i_pos_valid = 1'b1;
      i_pos_sop   = (sq == 0);
      i_pos_data  = board_codes[sq];
    end
    @(negedge clk);
    i_pos_valid = 1'b0;
    i_pos_sop   = 1'b0;
    i_pos_data  = '0;
    i_start     = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    idx     = 0;
    ended   = 1'b0;
    while (!ended) begin
      @(negedge clk);
      if (o_uci_valid) begin
        got_moves.push_back(o_uci_data);
        if (idx < exp_moves.size()) begin
          compare_value("o_uci_data", 32'(exp_moves[idx]), 32'(o_uci_data));
        end
        compare_value("o_uci_sop", 32'(idx == 0), 32'(o_uci_sop));
        compare_value("o_uci_eop", 32'(idx == exp_moves.size() - 1), 32'(o_uci_eop));
        idx++;
      end else begin
        compare_value("o_uci_sop", 32'(0), 32'(o_uci_sop));
      end
      if (o_uci_eop) begin
        lone_eop = !o_uci_valid;
        ended    = 1'b1;
      end
    end
    compare_value("move count", exp_moves.size(), idx);
  endtask

  // hard stop if a list never ends
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles without the end of a move list", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int mark;
    int side;
    i_pos_valid = 1'b0;
    i_pos_sop   = 1'b0;
    i_pos_data  = '0;
    i_wtp       = 1'b0;
    i_start     = 1'b0;
    lfsr_state  = 16'd54038;
    @(negedge clk);
    while (i_rst) begin
      @(negedge clk);
    end

    // with no stimulus the outputs stay quiet
    mark = errors;
    repeat (8) begin
      @(negedge clk);
      compare_value("o_uci_valid", 32'(0), 32'(o_uci_valid));
      compare_value("o_uci_eop", 32'(0), 32'(o_uci_eop));
      compare_value("o_uci_sop", 32'(0), 32'(o_uci_sop));
    end
    report_test("reset_idle", mark);

    mark = errors;
    for (int n = 0; n < RANDOM_RUNS; n++) begin
      make_random_board();
      take_bits(1, side);
      run_position(side[0]);
    end
    report_test("random_positions", mark);

    // white holds a rook boxed in on a1 and pawns only
    mark = errors;
    clear_board();
    board_codes[0]  = {1'b1, movegen_pkg::PC_ROOK};
    board_codes[1]  = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[8]  = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[12] = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[59] = {1'b0, movegen_pkg::PC_QUEEN};
    board_codes[60] = {1'b0, movegen_pkg::PC_KING};
    run_position(1'b1);
    expect_true(lone_eop, "a side without moves did not give a lone o_uci_eop");
    report_test("no_moves", mark);

    // d4 rook walled in by its own pawns, h1 rook facing a knight on h3 and a bishop on g1
    mark = errors;
    clear_board();
    board_codes[27] = {1'b1, movegen_pkg::PC_ROOK};
    board_codes[35] = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[19] = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[26] = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[28] = {1'b1, movegen_pkg::PC_PAWN};
    board_codes[7]  = {1'b1, movegen_pkg::PC_ROOK};
    board_codes[23] = {1'b0, movegen_pkg::PC_KNIGHT};
    board_codes[6]  = {1'b0, movegen_pkg::PC_BISHOP};
    board_codes[60] = {1'b0, movegen_pkg::PC_KING};
    run_position(1'b1);
    expect_true(count_from(27) == 0, "the walled-in rook on d4 produced a move");
    expect_true(contains_move(pack_move(movegen_pkg::PC_ROOK, 7, 23)),
                "the capture of the knight on h3 is missing");
    expect_true(contains_move(pack_move(movegen_pkg::PC_ROOK, 7, 6)),
                "the capture of the bishop on g1 is missing");
    report_test("slider_blocking", mark);

    // one position, white list first and then black
    mark = errors;
    make_random_board();
    run_position(1'b1);
    check_colours(1'b1);
    run_position(1'b0);
    check_colours(1'b0);
    report_test("colour_select", mark);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/movegen_pkg.sv
source/cand_if.sv
source/piece_stack.sv
source/move_queue.sv
source/board_square.sv
source/board_grid.sv
source/target_scan.sv
source/uci_emitter.sv
source/movegen_top.sv
sim/tb_clock.sv
sim/tb_movegen.sv

// ==== Makefile ====
TOP := tb_movegen

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
